/* obj_patterns.txt */
# t name line, then o index code xpos ypos hflip vflip pal (decimal), other entries stay off the line
# p four pairs of hdump (decimal) and expected pxl (hex)
t plain 40
o 3 5 20 35 0 0 2
p 19 00 20 2a 21 2b 26 00
p 27 21 28 2b 33 00 34 21
p 35 22 36 00 0 00 511 00
t flips 200
o 0 9 100 197 1 1 7
o 1 2 300 200 0 1 3
p 100 00 101 7f 104 7c 107 79
p 108 7f 111 7c 115 78 116 00
p 300 3e 301 3f 302 00 303 31
p 308 3f 309 00 310 31 315 36
t range 5
o 0 1 10 6 0 0 1
o 1 1 40 501 0 0 1
o 2 1 70 502 0 0 4
o 4 1 130 5 0 0 6
p 10 00 11 00 17 00 25 00
p 41 00 42 00 50 00 55 00
p 70 4e 71 4f 72 00 78 4f
p 130 00 131 61 137 67 138 61
t overlap 64
o 2 1 58 58 0 0 2
o 7 1 50 60 0 0 1
p 50 18 57 1f 58 2c 59 2d
p 61 2f 62 1d 63 21 65 23
p 66 2d 69 00 70 21 74 00
t many 128
o 0 1 0 128 0 0 1
o 4 1 32 127 0 0 2
o 8 1 64 126 0 0 3
o 12 1 96 125 1 0 4
o 20 1 400 124 0 1 5
o 31 1 500 123 0 0 6
p 0 6f 1 11 15 18 32 22
p 47 2a 64 34 79 3c 96 4e
p 103 47 104 4d 111 46 400 56
p 415 5e 500 6a 511 6e 2 12
t cleared 128
p 0 00 1 00 15 00 32 00
p 96 00 400 00 500 00 511 00

/* vlog.f */
obj_pkg.sv
obj_ifs.sv
obj_dispatch.sv
obj_draw.sv
obj_rom_arb.sv
obj_line_buf.sv
obj_engine.sv
tb_obj_engine.sv

/* tb_obj_engine.sv */
// sprite engine testbench with clock, reset, rom model, pattern reader, line scan and checks
`timescale 1ns/100ps
`default_nettype none

module tb_obj_engine;

    localparam int NUNITS      = 2;
    localparam int LINE_CYCLES = 1200;   // fixed gap between the two hs pulses of a test

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic                      tbl_we;
    logic [obj_pkg::IW-1:0]    tbl_addr;
    obj_pkg::obj_attr_t        tbl_data;
    logic                      hs;
    logic [8:0]                vrender;
    logic                      pxl_cen;
    logic [8:0]                hdump;
    logic [obj_pkg::PW-1:0]    pxl;
    logic                      rom_cs;
    logic [obj_pkg::RAW-1:0]   rom_addr;
    logic                      rom_ok;
    logic [31:0]               rom_data;

    integer seed       = 65;
    int     rom_cnt    = -1;     // cycles left before ok, -1 when idle
    int     run_cycles = 0;      // watchdog limit, known once the file is read
    int     errors     = 0;
    int     checks     = 0;

    // tests as read from the pattern file
    logic [8*16-1:0]     test_name [$];
    int                  test_line [$];
    int                  ent_test  [$];   // owning test of each table entry
    int                  ent_idx   [$];
    obj_pkg::obj_attr_t  ent_attr  [$];
    int                  pix_test  [$];   // owning test of each expected pixel
    int                  pix_x     [$];
    logic [7:0]          pix_val   [$];

    obj_engine #(.NUNITS(NUNITS)) obj_engine_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .tbl_we   (tbl_we),
        .tbl_addr (tbl_addr),
        .tbl_data (tbl_data),
        .hs       (hs),
        .vrender  (vrender),
        .pxl_cen  (pxl_cen),
        .hdump    (hdump),
        .pxl      (pxl),
        .rom_cs   (rom_cs),
        .rom_addr (rom_addr),
        .rom_ok   (rom_ok),
        .rom_data (rom_data)
    );

    always #2 clk = ~clk;        // 4 ns period

    // nibble k of a rom word is the low address bits plus k
    function automatic logic [31:0] rom_word(input logic [obj_pkg::RAW-1:0] a);
        logic [31:0] w;
        for (int k = 0; k < 8; k++) begin
            w[4*k +: 4] = a[3:0] + 4'(k);
        end
        return w;
    endfunction

    // rom model answering each request after 1 to 4 cycles
    always @(posedge clk) begin
        #0.5;
        rom_ok   = 1'b0;
        rom_data = 32'd0;
        if (!rst_n) begin
            rom_cnt = -1;
        end else if (rom_cnt > 0) begin
            rom_cnt = rom_cnt - 1;
        end else if (rom_cnt == 0) begin
            rom_ok   = 1'b1;                              // request still held here
            rom_data = rom_word(rom_addr);
            rom_cnt  = -1;
        end else if (rom_cs) begin
            rom_cnt = $unsigned($random(seed)) % 4;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #0.5;                                             // inputs move just after the edge
    endtask

    task automatic check(input logic [8*16-1:0] name, input int x,
                         input logic [7:0] expected, input logic [7:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %0s hdump %0d: expected %h, actual %h",
                     name, x, expected, actual);
        end
    endtask

    task automatic write_entry(input int idx, input obj_pkg::obj_attr_t a);
        tbl_we   = 1'b1;
        tbl_addr = obj_pkg::IW'(idx);
        tbl_data = a;
        next_cycle();
        tbl_we   = 1'b0;
    endtask

    task automatic pulse_hs(input int line);
        hs      = 1'b1;
        vrender = 9'(line);
        repeat (2) next_cycle();
        hs      = 1'b0;
        repeat (2) next_cycle();
    endtask

    task automatic read_patterns(output int file_ok);
        int                 fd;
        int                 n;
        int                 want;
        int                 v [8];
        logic [7:0]         cmd;
        logic [8*128-1:0]   rest;
        logic [8*16-1:0]    name;
        obj_pkg::obj_attr_t a;
        fd      = $fopen("obj_patterns.txt", "r");
        file_ok = (fd != 0);
        while (file_ok && $fscanf(fd, " %c", cmd) == 1) begin
            case (cmd)
                "#": begin                                // comment to end of line
                    n    = $fgets(rest, fd);
                    want = n;
                end
                "t": begin
                    want = 2;
                    n    = $fscanf(fd, "%s %d", name, v[0]);
                    test_name.push_back(name);
                    test_line.push_back(v[0]);
                end
                "o": begin                                // index code xpos ypos hflip vflip pal
                    want    = 7;
                    n       = $fscanf(fd, "%d %d %d %d %d %d %d",
                                      v[0], v[1], v[2], v[3], v[4], v[5], v[6]);
                    a.code  = v[1][obj_pkg::CW-1:0];
                    a.xpos  = v[2][8:0];
                    a.ypos  = v[3][8:0];
                    a.hflip = v[4][0];
                    a.vflip = v[5][0];
                    a.pal   = v[6][3:0];
                    ent_test.push_back(test_line.size() - 1);
                    ent_idx.push_back(v[0]);
                    ent_attr.push_back(a);
                end
                "p": begin                                // four hdump, pxl pairs
                    want = 8;
                    n    = $fscanf(fd, "%d %h %d %h %d %h %d %h",
                                   v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
                    for (int i = 0; i < 8; i += 2) begin
                        pix_test.push_back(test_line.size() - 1);
                        pix_x.push_back(v[i]);
                        pix_val.push_back(v[i+1][7:0]);
                    end
                end
                default: begin
                    want = 1;
                    n    = 0;
                end
            endcase
            if (n != want) begin
                $display("pattern file: unreadable line starting with '%c'", cmd);
                file_ok = 0;
            end
        end
        if (fd != 0) $fclose(fd);
    endtask

    task automatic run_test(input int t);
        obj_pkg::obj_attr_t tbl [obj_pkg::NOBJ];
        logic [7:0]         line_pix [512];
        int                 l;
        int                 fails;
        l     = test_line[t];
        fails = errors;
        for (int i = 0; i < obj_pkg::NOBJ; i++) begin
            tbl[i]      = '0;
            tbl[i].ypos = 9'(l + 256);                    // half a frame away, never hit
        end
        foreach (ent_test[e]) begin
            if (ent_test[e] == t) tbl[ent_idx[e]] = ent_attr[e];
        end
        for (int i = 0; i < obj_pkg::NOBJ; i++) begin
            write_entry(i, tbl[i]);
        end
        pulse_hs(l);                                      // line l drawn into the back half
        repeat (LINE_CYCLES) next_cycle();
        pulse_hs(l + 1);                                  // swap, line l reads out now
        pxl_cen = 1'b1;
        for (int x = 0; x < 512; x++) begin
            hdump = 9'(x);
            next_cycle();
            line_pix[x] = pxl;                            // registered pixel for this hdump
        end
        pxl_cen = 1'b0;
        foreach (pix_test[p]) begin
            if (pix_test[p] == t) check(test_name[t], pix_x[p], pix_val[p], line_pix[pix_x[p]]);
        end
        fails = errors - fails;
        $display("test %0s line %0d: %0s, %0d mismatches",
                 test_name[t], l, (fails == 0) ? "ok" : "failed", fails);
    endtask

    // watchdog sized from the number of tests
    initial begin
        wait (run_cycles > 0);
        repeat (run_cycles) @(posedge clk);
        $display("timeout: run still going after %0d cycles", run_cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        int file_ok;
        rst_n    = 1'b0;
        tbl_we   = 1'b0;
        tbl_addr = '0;
        tbl_data = '0;
        hs       = 1'b0;
        vrender  = '0;
        pxl_cen  = 1'b0;
        hdump    = '0;
        rom_ok   = 1'b0;
        rom_data = '0;
        read_patterns(file_ok);
        if (!file_ok || test_line.size() == 0) begin
            $display("pattern file obj_patterns.txt is missing or malformed");
            errors++;
        end else begin
            run_cycles = (test_line.size() + 2) * 2 * LINE_CYCLES;
            repeat (16) next_cycle();
            rst_n = 1'b1;
            repeat (520) next_cycle();                    // buffer clears one x per cycle
            for (int t = 0; t < test_line.size(); t++) begin
                run_test(t);
            end
        end
        $display("done: %0d tests, %0d checks, %0d mismatches",
                 test_line.size(), checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* obj_engine.sv */
// sprite line engine top level with dispatcher, draw units, rom arbiter and line buffer
`timescale 1ns/100ps
`default_nettype none

module obj_engine #(
    parameter int NUNITS = 2   // 1 to 4
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      tbl_we,
    input  wire  [obj_pkg::IW-1:0]   tbl_addr,
    input  wire  obj_pkg::obj_attr_t tbl_data,
    input  wire                      hs,
    input  wire  [8:0]               vrender,
    input  wire                      pxl_cen,
    input  wire  [8:0]               hdump,
    output logic [obj_pkg::PW-1:0]   pxl,
    output logic                     rom_cs,
    output logic [obj_pkg::RAW-1:0]  rom_addr,
    input  wire                      rom_ok,
    input  wire  [31:0]              rom_data
);

    logic [NUNITS-1:0]  draw;
    logic [NUNITS-1:0]  busy;
    obj_pkg::obj_job_t  job [NUNITS];

    obj_rom_if rom_bus [NUNITS] ();   // unit to arbiter
    obj_buf_if wr_bus  [NUNITS] ();   // unit to line buffer

    obj_dispatch #(.NUNITS(NUNITS)) u_dispatch (
        .clk      (clk),
        .rst_n    (rst_n),
        .tbl_we   (tbl_we),
        .tbl_addr (tbl_addr),
        .tbl_data (tbl_data),
        .hs       (hs),
        .vrender  (vrender),
        .busy     (busy),
        .draw     (draw),
        .job      (job)
    );

    for (genvar g = 0; g < NUNITS; g++) begin : g_unit
        obj_draw u_draw (
            .clk   (clk),
            .rst_n (rst_n),
            .draw  (draw[g]),
            .busy  (busy[g]),
            .job   (job[g]),
            .rom   (rom_bus[g]),
            .wr    (wr_bus[g])
        );
    end

    obj_rom_arb #(.NUNITS(NUNITS)) u_rom_arb (
        .clk      (clk),
        .rst_n    (rst_n),
        .units    (rom_bus),
        .rom_cs   (rom_cs),
        .rom_addr (rom_addr),
        .rom_ok   (rom_ok),
        .rom_data (rom_data)
    );

    obj_line_buf #(.NUNITS(NUNITS)) u_line_buf (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (wr_bus),
        .hs      (hs),
        .pxl_cen (pxl_cen),
        .hdump   (hdump),
        .pxl     (pxl)
    );

endmodule

`default_nettype wire

/* obj_line_buf.sv */
// double line buffer with priority-merging write port and read-then-clear port
`timescale 1ns/100ps
`default_nettype none

module obj_line_buf #(
    parameter int NUNITS = 2
) (
    input  wire                      clk,
    input  wire                      rst_n,
    obj_buf_if.lbuf                  wr [NUNITS],
    input  wire                      hs,
    input  wire                      pxl_cen,
    input  wire  [8:0]               hdump,
    output logic [obj_pkg::PW-1:0]   pxl
);

    localparam int IW = obj_pkg::IW;
    localparam int PW = obj_pkg::PW;
    localparam int EW = 1 + IW + PW;     // {valid, prio, pixel}

    logic [EW-1:0]      mem [1024];      // {half, x}
    logic               wsel;            // half being written
    logic               hs_l;
    logic               init;            // clearing both halves after reset
    logic [8:0]         icnt;

    logic [NUNITS-1:0]  we;
    logic [NUNITS-1:0]  gnt;
    logic [8:0]         waddr [NUNITS];
    logic [PW-1:0]      wdin  [NUNITS];
    logic [IW-1:0]      wprio [NUNITS];

    logic               take;
    logic [8:0]         ta;
    logic [PW-1:0]      td;
    logic [IW-1:0]      tp;
    logic [EW-1:0]      old;             // entry under the write
    logic               store;
    logic [EW-1:0]      rd;              // entry under the read

    for (genvar g = 0; g < NUNITS; g++) begin : g_port
        assign we[g]    = wr[g].we;
        assign waddr[g] = wr[g].addr;
        assign wdin[g]  = wr[g].din;
        assign wprio[g] = wr[g].prio;
        assign wr[g].ok = gnt[g];
    end

    // fixed priority, lowest unit first, one write per cycle
    always_comb begin
        gnt  = '0;
        take = 1'b0;
        ta   = '0;
        td   = '0;
        tp   = '0;
        for (int g = NUNITS - 1; g >= 0; g--) begin
            if (we[g]) begin
                gnt    = '0;
                gnt[g] = 1'b1;
                take   = 1'b1;
                ta     = waddr[g];
                td     = wdin[g];
                tp     = wprio[g];
            end
        end
        if (init) begin                  // hold writes until cleared
            gnt  = '0;
            take = 1'b0;
        end
    end

    assign old   = mem[{wsel, ta}];
    // lower table index wins over what is already there
    assign store = take && (!old[EW-1] || tp < old[EW-2 -: IW]);
    assign rd    = mem[{~wsel, hdump}];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wsel <= 1'b0;
            hs_l <= 1'b0;
            init <= 1'b1;
            icnt <= '0;
            pxl  <= '0;
        end else begin
            hs_l <= hs;
            if (hs && !hs_l) wsel <= ~wsel;       // swap halves
            if (init) begin
                icnt <= icnt + 9'd1;
                if (&icnt) init <= 1'b0;
            end
            if (pxl_cen) pxl <= (!init && rd[EW-1]) ? rd[PW-1:0] : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (init) begin                             // one x per cycle, both halves
            mem[{1'b0, icnt}] <= '0;
            mem[{1'b1, icnt}] <= '0;
        end
        if (store) mem[{wsel, ta}] <= {1'b1, tp, td};
        if (pxl_cen) mem[{~wsel, hdump}] <= '0;     // clear after read
    end

endmodule

`default_nettype wire

/* obj_rom_arb.sv */
// round-robin arbiter sharing the graphics rom port among the draw units
`timescale 1ns/100ps
`default_nettype none

module obj_rom_arb #(
    parameter int NUNITS = 2
) (
    input  wire                      clk,
    input  wire                      rst_n,
    obj_rom_if.arb                   units [NUNITS],
    output logic                     rom_cs,
    output logic [obj_pkg::RAW-1:0]  rom_addr,
    input  wire                      rom_ok,
    input  wire  [31:0]              rom_data
);

    localparam int SW = (NUNITS > 1) ? $clog2(NUNITS) : 1;

    logic [NUNITS-1:0]        req;
    logic [NUNITS-1:0]        gnt;
    logic [obj_pkg::RAW-1:0]  addr [NUNITS];
    logic [SW-1:0]            own;    // last or current owner
    logic [SW-1:0]            sel;
    logic                     lock;   // request open, owner fixed

    for (genvar g = 0; g < NUNITS; g++) begin : g_port
        assign req[g]        = units[g].cs;
        assign addr[g]       = units[g].addr;
        assign units[g].ok   = rom_ok & gnt[g];
        assign units[g].data = gnt[g] ? rom_data : 32'd0;
    end

    // next requester after the owner, unless a request is pending
    always_comb begin
        sel = own;
        if (!lock) begin
            for (int i = NUNITS; i >= 1; i--) begin
                if (req[(own + i) % NUNITS]) sel = SW'((own + i) % NUNITS);
            end
        end
    end

    assign rom_cs   = req[sel];
    assign rom_addr = addr[sel];
    assign gnt      = rom_cs ? (NUNITS'(1) << sel) : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            own  <= '0;
            lock <= 1'b0;
        end else if (rom_cs) begin
            own  <= sel;
            lock <= !rom_ok;                // released on ok
        end
    end

    // an open request keeps its owner, cs and address until ok
    a_gnt_held: assert property (@(posedge clk) disable iff (!rst_n)
        rom_cs && !rom_ok |=> rom_cs && gnt == $past(gnt) && $stable(rom_addr));

endmodule

`default_nettype wire

/* obj_draw.sv */
// draw unit that latches a job, fetches two rom words and writes 16 flipped pixels
`timescale 1ns/100ps
`default_nettype none

module obj_draw (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 draw,
    output logic                busy,
    input  wire obj_pkg::obj_job_t job,
    obj_rom_if.unit             rom,
    obj_buf_if.unit             wr
);

    obj_pkg::obj_job_t j;       // latched job
    logic              fetch;   // waiting on the rom
    logic              half;    // screen half being drawn, left first
    logic [2:0]        col;     // column inside the half
    logic [31:0]       data;    // current rom word
    logic [3:0]        row;
    logic [2:0]        k;       // nibble index inside the word
    logic [3:0]        nib;
    logic              step;    // current column done this cycle
    logic              last_col;

    // rom side
    assign row      = j.vflip ? ~j.ysub : j.ysub;     // 15 - ysub when flipped
    assign rom.cs   = busy & fetch;
    assign rom.addr = {j.code, row, half ^ j.hflip};  // hflip swaps the halves

    // pixel side
    assign k        = col ^ {3{j.hflip}};             // reversed nibble order
    assign nib      = data[{k, 2'b00} +: 4];
    assign wr.we    = busy & ~fetch & (nib != 4'd0);  // 0 is transparent
    assign wr.addr  = j.xpos + {5'd0, half, col};     // wraps at 512
    assign wr.din   = {j.pal, nib};
    assign wr.prio  = j.prio;

    assign step     = busy & ~fetch & ((nib == 4'd0) | wr.ok);
    assign last_col = (col == 3'd7);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            fetch <= 1'b0;
        end else if (draw) begin
            busy  <= 1'b1;
            fetch <= 1'b1;
        end else if (rom.cs && rom.ok) begin
            fetch <= 1'b0;                  // word in, start writing
        end else if (step && last_col) begin
            if (half) busy <= 1'b0;         // last pixel of the right half
            else      fetch <= 1'b1;        // go for the right half
        end
    end

    always_ff @(posedge clk) begin
        if (draw) begin
            j    <= job;
            half <= 1'b0;
        end
        if (rom.cs && rom.ok) begin
            data <= rom.data;
            col  <= 3'd0;
        end
        if (step) begin
            col <= col + 3'd1;
            if (last_col) half <= 1'b1;
        end
    end

    // the dispatcher only picks idle units
    a_draw_free: assert property (@(posedge clk) disable iff (!rst_n)
        draw |-> !busy);

endmodule

`default_nettype wire

/* obj_dispatch.sv */
// sprite table ram, line scan with range test and job hand-off to free draw units
`timescale 1ns/100ps
`default_nettype none

module obj_dispatch #(
    parameter int NUNITS = 2
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          tbl_we,
    input  wire  [obj_pkg::IW-1:0]       tbl_addr,
    input  wire  obj_pkg::obj_attr_t     tbl_data,
    input  wire                          hs,
    input  wire  [8:0]                   vrender,
    input  wire  [NUNITS-1:0]            busy,
    output logic [NUNITS-1:0]            draw,
    output obj_pkg::obj_job_t            job [NUNITS]
);

    obj_pkg::obj_attr_t     tbl [obj_pkg::NOBJ];  // attribute table
    obj_pkg::obj_attr_t     cur;                  // entry under test
    obj_pkg::obj_job_t      nj;                   // job built from cur
    logic                   hs_l;
    logic                   scan;                 // walking the table
    logic [8:0]             line;                 // line latched at hs
    logic [obj_pkg::IW-1:0] idx;
    logic [8:0]             dy;
    logic                   hit;
    logic [NUNITS-1:0]      free;
    logic [NUNITS-1:0]      pick;                 // one-hot, lowest free unit

    always_ff @(posedge clk) begin
        if (tbl_we) tbl[tbl_addr] <= tbl_data;
    end

    assign cur  = tbl[idx];
    assign dy   = line - cur.ypos;                // wraps at 512
    assign hit  = scan && (dy[8:4] == 5'd0);      // 16 rows tall
    // a unit drawn this cycle only shows busy on the next one
    assign free = ~busy & ~draw;

    always_comb begin
        pick = '0;
        for (int u = NUNITS - 1; u >= 0; u--) begin
            if (free[u]) begin
                pick    = '0;
                pick[u] = 1'b1;
            end
        end
    end

    always_comb begin
        nj.code  = cur.code;
        nj.xpos  = cur.xpos;
        nj.ysub  = dy[3:0];
        nj.hflip = cur.hflip;
        nj.vflip = cur.vflip;
        nj.pal   = cur.pal;
        nj.prio  = idx;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hs_l <= 1'b0;
            scan <= 1'b0;
            idx  <= '0;
            line <= '0;
            draw <= '0;
        end else begin
            hs_l <= hs;
            draw <= '0;                           // one cycle pulse
            if (hs && !hs_l) begin                // new line restarts the walk
                scan <= 1'b1;
                idx  <= '0;
                line <= vrender;
            end else if (scan && (!hit || |pick)) begin // stall while all units busy
                if (hit) draw <= pick;
                idx <= idx + 1'b1;
                if (idx == obj_pkg::IW'(obj_pkg::NOBJ - 1)) scan <= 1'b0;
            end
        end
    end

    // job registers, read by the unit only while its draw is high
    always_ff @(posedge clk) begin
        for (int u = 0; u < NUNITS; u++) begin
            if (hit && pick[u]) job[u] <= nj;
        end
    end

    a_draw_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (draw & busy) == '0);

endmodule

`default_nettype wire

/* obj_ifs.sv */
// graphics rom request interface and line buffer write interface
`timescale 1ns/100ps
`default_nettype none

// cs/addr held until ok, data valid with ok
interface obj_rom_if;
    logic                     cs;
    logic [obj_pkg::RAW-1:0]  addr;   // {code, row, half}
    logic                     ok;
    logic [31:0]              data;   // 8 pixels, nibble 0 is the leftmost

    modport unit (output cs, addr, input ok, data);
    modport arb  (input cs, addr, output ok, data);
endinterface

// write taken when we and ok are both high
interface obj_buf_if;
    logic                     we;
    logic [8:0]               addr;
    logic [obj_pkg::PW-1:0]   din;
    logic [obj_pkg::IW-1:0]   prio;
    logic                     ok;

    modport unit (output we, addr, din, prio, input ok);
    // line buffer side
    modport lbuf (input we, addr, din, prio, output ok);
endinterface

`default_nettype wire

/* obj_pkg.sv */
// fixed widths, sprite attribute struct and draw job struct
`default_nettype none

package obj_pkg;

    localparam int CW   = 10;            // sprite code width
    localparam int NOBJ = 32;            // entries in the attribute table
    localparam int IW   = $clog2(NOBJ);  // table index width
    localparam int PW   = 8;             // pixel: palette on top, rom nibble below
    localparam int RAW  = CW + 5;        // rom word address: code, row, half

    // one table entry, also the table write data (34 bits)
    typedef struct packed {
        logic [CW-1:0] code;
        logic [8:0]    xpos;
        logic [8:0]    ypos;
        logic          hflip;
        logic          vflip;
        logic [PW-5:0] pal;
    } obj_attr_t;

    // what a draw unit needs for one sprite row
    typedef struct packed {
        logic [CW-1:0] code;
        logic [8:0]    xpos;
        logic [3:0]    ysub;   // row inside the sprite, before vflip
        logic          hflip;
        logic          vflip;
        logic [PW-5:0] pal;
        logic [IW-1:0] prio;   // table index, lower wins
    } obj_job_t;

endpackage

`default_nettype wire
